// File: lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    // negative, zero, positive from msb to lsb
    typedef logic [2:0]  lc3b_nzp;

    // standard lc-3b opcode field, 1010 and 1011 are unused
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_passa,
        alu_passb
    } lc3b_aluop;

    // carried from decode through execute to writeback
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        lc3b_word   pc;
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic       addr3mux_sel;
        logic       lshf;
        logic       sr2mux_sel;
        logic       br_op;
        logic       jsr_op;
        logic       trap_op;
        logic       jmp_op;
        logic       uncond_op;
        logic       dcache_read;
        logic       dcache_write;
        logic       dcache_enable;
        logic [1:0] wbmux_sel;
        logic       load_cc;
        logic       load_reg;
        logic       storemux_sel;
        logic       dest_mux_sel;
        logic       alu_result_mux_sel;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

// File: control_rom.sv
`default_nettype none

module control_rom
(
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         ir11,
    input  logic                         ir5,
    input  lc3b_types::lc3b_word         pc,
    output lc3b_types::lc3b_control_word ctrl
);

    always_comb
    begin
        // defaults, every field is set here
        ctrl.opcode             = opcode;
        ctrl.aluop              = lc3b_types::alu_passa;
        ctrl.pc                 = pc;
        ctrl.addr1mux_sel       = 1'b0;
        ctrl.addr2mux_sel       = 2'b00;
        ctrl.addr3mux_sel       = 1'b0;
        ctrl.lshf               = 1'b0;
        ctrl.sr2mux_sel         = 1'b0;
        ctrl.br_op              = 1'b0;
        ctrl.jsr_op             = 1'b0;
        ctrl.trap_op            = 1'b0;
        ctrl.jmp_op             = 1'b0;
        ctrl.uncond_op          = 1'b0;
        ctrl.dcache_read        = 1'b0;
        ctrl.dcache_write       = 1'b0;
        ctrl.dcache_enable      = 1'b0;
        ctrl.wbmux_sel          = 2'b00;
        ctrl.load_cc            = 1'b0;
        ctrl.load_reg           = 1'b0;
        ctrl.storemux_sel       = 1'b0;
        ctrl.dest_mux_sel       = 1'b0;
        ctrl.alu_result_mux_sel = 1'b0;

        case (opcode)
            lc3b_types::op_add,
            lc3b_types::op_and,
            lc3b_types::op_not,
            lc3b_types::op_shf:
            begin
                ctrl.load_reg  = 1'b1;
                ctrl.load_cc   = 1'b1;
                ctrl.wbmux_sel = 2'b11;
                // imm5 form of add and and
                ctrl.sr2mux_sel = ir5;
                if (opcode == lc3b_types::op_add)
                    ctrl.aluop = lc3b_types::alu_add;
                else if (opcode == lc3b_types::op_and)
                    ctrl.aluop = lc3b_types::alu_and;
                else if (opcode == lc3b_types::op_not)
                    ctrl.aluop = lc3b_types::alu_not;
                else
                    ctrl.alu_result_mux_sel = 1'b1;
            end

            lc3b_types::op_ldr,
            lc3b_types::op_ldb:
            begin
                // base + offset6, word offset scaled for ldr only
                ctrl.addr1mux_sel  = 1'b1;
                ctrl.addr2mux_sel  = 2'b01;
                ctrl.lshf          = (opcode == lc3b_types::op_ldr);
                ctrl.dcache_read   = 1'b1;
                ctrl.dcache_enable = 1'b1;
                ctrl.wbmux_sel     = 2'b01;
                ctrl.load_reg      = 1'b1;
                ctrl.load_cc       = 1'b1;
            end

            lc3b_types::op_str:
            begin
                ctrl.addr1mux_sel  = 1'b1;
                ctrl.addr2mux_sel  = 2'b01;
                ctrl.lshf          = 1'b1;
                // store source comes through the alu b input
                ctrl.storemux_sel  = 1'b1;
                ctrl.aluop         = lc3b_types::alu_passb;
                ctrl.dcache_write  = 1'b1;
                ctrl.dcache_enable = 1'b1;
            end

            lc3b_types::op_br,
            lc3b_types::op_lea:
            begin
                // pc + offset9 << 1
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf         = 1'b1;
                ctrl.br_op        = (opcode == lc3b_types::op_br);
                ctrl.load_reg     = (opcode == lc3b_types::op_lea);
                ctrl.load_cc      = (opcode == lc3b_types::op_lea);
            end

            lc3b_types::op_jmp:
            begin
                // ret is jmp through r7
                ctrl.addr1mux_sel = 1'b1;
                ctrl.jmp_op       = 1'b1;
                ctrl.uncond_op    = 1'b1;
                ctrl.load_reg     = 1'b1;
            end

            lc3b_types::op_jsr:
            begin
                ctrl.jsr_op       = 1'b1;
                ctrl.uncond_op    = 1'b1;
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg     = 1'b1;
                ctrl.wbmux_sel    = 2'b10;
                if (ir11)
                begin
                    ctrl.addr2mux_sel = 2'b11;
                    ctrl.lshf         = 1'b1;
                end
                else
                begin
                    // jsrr jumps to the base register
                    ctrl.addr1mux_sel = 1'b1;
                    ctrl.jmp_op       = 1'b1;
                end
            end

            lc3b_types::op_trap:
            begin
                // r7 gets the return pc, target is read from the vector table
                ctrl.trap_op      = 1'b1;
                ctrl.uncond_op    = 1'b1;
                ctrl.addr3mux_sel = 1'b1;
                ctrl.dcache_read  = 1'b1;
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg     = 1'b1;
                ctrl.wbmux_sel    = 2'b10;
            end

            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    lc3b_types::lc3b_word data [8];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
                data[i] <= '0;
        end
        else if (load)
        begin
            data[dest] <= in;
        end
    end

    // same-cycle write is seen by the reader
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  logic                  shift_sel,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    input  logic [5:0]            shift_ctl,
    output lc3b_types::lc3b_word  f
);

    lc3b_types::lc3b_word logic_f;
    lc3b_types::lc3b_word shift_f;

    always_comb
    begin
        case (aluop)
            lc3b_types::alu_add:   logic_f = a + b;
            lc3b_types::alu_and:   logic_f = a & b;
            lc3b_types::alu_not:   logic_f = ~a;
            lc3b_types::alu_passb: logic_f = b;
            default:               logic_f = a;
        endcase
    end

    // bit 4 picks right shift, bit 5 makes it arithmetic
    always_comb
    begin
        if (!shift_ctl[4])
            shift_f = a << shift_ctl[3:0];
        else if (shift_ctl[5])
            shift_f = lc3b_types::lc3b_word'($signed(a) >>> shift_ctl[3:0]);
        else
            shift_f = a >> shift_ctl[3:0];
    end

    assign f = shift_sel ? shift_f : logic_f;

endmodule : alu

`default_nettype wire

// File: lc3b_core.sv
`default_nettype none

module lc3b_core
(
    input  logic                 clk,
    input  logic                 rst,
    input  lc3b_types::lc3b_word instr,
    input  lc3b_types::lc3b_word instr_pc,
    input  logic                 instr_valid,
    input  lc3b_types::lc3b_word dmem_rdata,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp  cc_nzp,
    output logic                 redirect,
    output lc3b_types::lc3b_word redirect_target
);

    // decode stage
    logic                         d_valid;
    lc3b_types::lc3b_word         d_ir;
    lc3b_types::lc3b_word         d_pc;
    lc3b_types::lc3b_control_word d_ctrl;
    lc3b_types::lc3b_reg          d_src_b;
    lc3b_types::lc3b_word         d_a;
    lc3b_types::lc3b_word         d_b;

    // execute stage
    logic                         e_valid;
    logic [11:0]                  e_ir;
    lc3b_types::lc3b_control_word e_ctrl;
    lc3b_types::lc3b_word         e_a;
    lc3b_types::lc3b_word         e_b;
    lc3b_types::lc3b_word         e_alu_b;
    lc3b_types::lc3b_word         e_alu;
    lc3b_types::lc3b_word         addr1;
    lc3b_types::lc3b_word         addr2;
    lc3b_types::lc3b_word         e_addr;

    // writeback stage
    logic                         w_valid;
    lc3b_types::lc3b_reg          w_field;
    lc3b_types::lc3b_control_word w_ctrl;
    lc3b_types::lc3b_word         w_alu;
    lc3b_types::lc3b_word         w_addr;
    lc3b_types::lc3b_word         load_data;
    lc3b_types::lc3b_nzp          new_nzp;
    logic                         br_taken;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            w_valid <= 1'b0;
        end
        else
        begin
            d_valid <= instr_valid;
            e_valid <= d_valid;
            w_valid <= e_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            d_ir <= instr;
            d_pc <= instr_pc;
        end
        e_ir   <= d_ir[11:0];
        e_ctrl <= d_ctrl;
        e_a    <= d_a;
        e_b    <= d_b;
        w_field <= e_ir[11:9];
        w_ctrl  <= e_ctrl;
        w_alu   <= e_alu;
        w_addr  <= e_addr;
    end

    control_rom u_control_rom
    (
        .opcode (lc3b_types::lc3b_opcode'(d_ir[15:12])),
        .ir11   (d_ir[11]),
        .ir5    (d_ir[5]),
        .pc     (d_pc),
        .ctrl   (d_ctrl)
    );

    // stores read their source from the dr field
    assign d_src_b = d_ctrl.storemux_sel ? d_ir[11:9] : d_ir[2:0];

    regfile u_regfile
    (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_valid),
        .dest  (wb_dest),
        .in    (wb_data),
        .src_a (d_ir[8:6]),
        .src_b (d_src_b),
        .reg_a (d_a),
        .reg_b (d_b)
    );

    assign e_alu_b = e_ctrl.sr2mux_sel ? {{11{e_ir[4]}}, e_ir[4:0]} : e_b;

    alu u_alu
    (
        .aluop     (e_ctrl.aluop),
        .shift_sel (e_ctrl.alu_result_mux_sel),
        .a         (e_a),
        .b         (e_alu_b),
        .shift_ctl (e_ir[5:0]),
        .f         (e_alu)
    );

    // address adders
    always_comb
    begin
        addr1 = e_ctrl.addr1mux_sel ? e_a : e_ctrl.pc;
        case (e_ctrl.addr2mux_sel)
            2'b01:   addr2 = {{10{e_ir[5]}}, e_ir[5:0]};
            2'b10:   addr2 = {{7{e_ir[8]}}, e_ir[8:0]};
            2'b11:   addr2 = {{5{e_ir[10]}}, e_ir[10:0]};
            default: addr2 = '0;
        endcase
        if (e_ctrl.lshf)
            addr2 = {addr2[14:0], 1'b0};
        // trap vector table entry
        if (e_ctrl.addr3mux_sel)
            e_addr = {7'b0, e_ir[7:0], 1'b0};
        else
            e_addr = addr1 + addr2;
    end

    // ldb picks the byte by the low address bit
    always_comb
    begin
        if (w_ctrl.opcode == lc3b_types::op_ldb)
            load_data = {8'h00, w_addr[0] ? dmem_rdata[15:8] : dmem_rdata[7:0]};
        else
            load_data = dmem_rdata;
    end

    always_comb
    begin
        case (w_ctrl.wbmux_sel)
            2'b00:   wb_data = w_addr;
            2'b01:   wb_data = load_data;
            2'b10:   wb_data = w_ctrl.pc;
            default: wb_data = w_alu;
        endcase
    end

    assign wb_dest = w_ctrl.dest_mux_sel ? 3'd7 : w_field;
    // jmp carries load_reg from the rom but never writes
    assign wb_valid = w_valid && w_ctrl.load_reg && !(w_ctrl.jmp_op && !w_ctrl.jsr_op);

    always_comb
    begin
        if (wb_data[15])
            new_nzp = 3'b100;
        else if (wb_data == '0)
            new_nzp = 3'b010;
        else
            new_nzp = 3'b001;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            cc_nzp <= 3'b010;
        else if (wb_valid && w_ctrl.load_cc)
            cc_nzp <= new_nzp;
    end

    // branch mask sits in the dr field
    assign br_taken = w_ctrl.br_op && ((w_field & cc_nzp) != 3'b000);
    assign redirect = w_valid && (br_taken || w_ctrl.uncond_op);
    assign redirect_target = w_ctrl.trap_op ? dmem_rdata : w_addr;

    assign dmem_read = w_valid && w_ctrl.dcache_read
                       && (w_ctrl.dcache_enable || w_ctrl.trap_op);
    assign dmem_write = w_valid && w_ctrl.dcache_write
                        && (w_ctrl.dcache_enable || w_ctrl.trap_op);
    assign dmem_addr  = w_addr;
    assign dmem_wdata = w_alu;

endmodule : lc3b_core

`default_nettype wire

// File: tb_lc3b_core.sv
`default_nettype none

module tb_lc3b_core;

    // each single-instruction block spans issue, D, E, W and the cc check
    localparam int block_cycles    = 5;
    localparam int idle_cycles     = 4 + 3 + block_cycles;
    localparam int arith_cycles    = 10 * block_cycles;
    localparam int pipe_cycles     = 4 + 4;
    localparam int mem_cycles      = 6 * block_cycles;
    localparam int ctrl_cycles     = 33 * block_cycles;
    localparam int watchdog_cycles = idle_cycles + arith_cycles + pipe_cycles
                                     + mem_cycles + ctrl_cycles + 100;

    typedef struct packed {
        logic                 wb;
        logic                 cc;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word data;
        logic                 redir;
        lc3b_types::lc3b_word target;
        logic                 rd;
        logic                 wr;
        lc3b_types::lc3b_word addr;
        lc3b_types::lc3b_word wdata;
    } outcome_t;

    logic                 clk;
    logic                 rst;
    lc3b_types::lc3b_word instr;
    lc3b_types::lc3b_word instr_pc;
    logic                 instr_valid;
    lc3b_types::lc3b_word dmem_rdata;
    logic                 dmem_read;
    logic                 dmem_write;
    lc3b_types::lc3b_word dmem_addr;
    lc3b_types::lc3b_word dmem_wdata;
    logic                 wb_valid;
    lc3b_types::lc3b_reg  wb_dest;
    lc3b_types::lc3b_word wb_data;
    lc3b_types::lc3b_nzp  cc_nzp;
    logic                 redirect;
    lc3b_types::lc3b_word redirect_target;

    // data memory seen by the DUT, and the reference copy
    lc3b_types::lc3b_word mem [64];
    lc3b_types::lc3b_word ref_mem [64];
    lc3b_types::lc3b_word m_reg [8];
    lc3b_types::lc3b_nzp  m_nzp;

    lc3b_types::lc3b_word ir_q [$];
    lc3b_types::lc3b_word pc_q [$];
    lc3b_types::lc3b_word lfsr_state;
    string                test_name;
    int                   test_start_errors;
    int                   error_count;
    int                   pass_count;
    int                   fail_count;

    lc3b_core u_dut
    (
        .clk             (clk),
        .rst             (rst),
        .instr           (instr),
        .instr_pc        (instr_pc),
        .instr_valid     (instr_valid),
        .dmem_rdata      (dmem_rdata),
        .dmem_read       (dmem_read),
        .dmem_write      (dmem_write),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .wb_valid        (wb_valid),
        .wb_dest         (wb_dest),
        .wb_data         (wb_data),
        .cc_nzp          (cc_nzp),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    function automatic lc3b_types::lc3b_word fill_word(input logic [5:0] idx);
        return {2'b10, idx, ~idx, 2'b01};
    endfunction

    // zero-wait memory, byte address to word index
    assign dmem_rdata = mem[dmem_addr[6:1]];

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 64; i++)
                mem[i[5:0]] <= fill_word(i[5:0]);
        end
        else if (dmem_write)
        begin
            mem[dmem_addr[6:1]] <= dmem_wdata;
        end
    end

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * 10);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    // galois lfsr, taps 16,14,13,11
    function automatic lc3b_types::lc3b_word lfsr_next(input lc3b_types::lc3b_word s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        else
            return s >> 1;
    endfunction

    task automatic random_bits(input int n, output lc3b_types::lc3b_word v);
        v = '0;
        repeat (n)
        begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic lc3b_types::lc3b_word enc(input lc3b_types::lc3b_opcode op,
                                                 input logic [2:0] a, input logic [2:0] b,
                                                 input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    function automatic lc3b_types::lc3b_nzp nzp_of(input lc3b_types::lc3b_word v);
        if (v[15])
            return 3'b100;
        else if (v == 16'h0000)
            return 3'b010;
        else
            return 3'b001;
    endfunction

    // architectural effect of one instruction on the reference state
    function automatic outcome_t predict(input lc3b_types::lc3b_word ir,
                                         input lc3b_types::lc3b_word pc);
        outcome_t             e;
        lc3b_types::lc3b_word sr1;
        lc3b_types::lc3b_word sr2;
        lc3b_types::lc3b_word imm5;
        lc3b_types::lc3b_word off6;
        lc3b_types::lc3b_word off9;
        lc3b_types::lc3b_word off11;
        lc3b_types::lc3b_word word;
        e     = '0;
        sr1   = m_reg[ir[8:6]];
        sr2   = m_reg[ir[2:0]];
        imm5  = {{11{ir[4]}}, ir[4:0]};
        off6  = {{10{ir[5]}}, ir[5:0]};
        off9  = {{7{ir[8]}}, ir[8:0]};
        off11 = {{5{ir[10]}}, ir[10:0]};
        e.dest = ir[11:9];
        case (lc3b_types::lc3b_opcode'(ir[15:12]))
            lc3b_types::op_add: e.data = sr1 + (ir[5] ? imm5 : sr2);
            lc3b_types::op_and: e.data = sr1 & (ir[5] ? imm5 : sr2);
            lc3b_types::op_not: e.data = ~sr1;
            lc3b_types::op_shf:
            begin
                if (!ir[4])
                    e.data = sr1 << ir[3:0];
                else if (!ir[5])
                    e.data = sr1 >> ir[3:0];
                else
                    e.data = (sr1 >> ir[3:0]) | (sr1[15] ? ~(16'hFFFF >> ir[3:0]) : 16'h0000);
            end
            lc3b_types::op_lea: e.data = pc + (off9 << 1);
            lc3b_types::op_ldr:
            begin
                e.rd   = 1'b1;
                e.addr = sr1 + (off6 << 1);
                e.data = ref_mem[e.addr[6:1]];
            end
            lc3b_types::op_ldb:
            begin
                e.rd   = 1'b1;
                e.addr = sr1 + off6;
                word   = ref_mem[e.addr[6:1]];
                e.data = {8'h00, e.addr[0] ? word[15:8] : word[7:0]};
            end
            lc3b_types::op_str:
            begin
                e.wr    = 1'b1;
                e.addr  = sr1 + (off6 << 1);
                e.wdata = m_reg[ir[11:9]];
            end
            lc3b_types::op_br:
            begin
                e.redir  = |(ir[11:9] & m_nzp);
                e.target = pc + (off9 << 1);
            end
            lc3b_types::op_jmp:
            begin
                e.redir  = 1'b1;
                e.target = sr1;
            end
            lc3b_types::op_jsr:
            begin
                e.redir  = 1'b1;
                e.target = ir[11] ? pc + (off11 << 1) : sr1;
                e.dest   = 3'd7;
                e.data   = pc;
                e.wb     = 1'b1;
            end
            lc3b_types::op_trap:
            begin
                e.rd     = 1'b1;
                e.addr   = {7'b0, ir[7:0], 1'b0};
                e.redir  = 1'b1;
                e.target = ref_mem[e.addr[6:1]];
                e.dest   = 3'd7;
                e.data   = pc;
                e.wb     = 1'b1;
            end
            default: e = '0;
        endcase
        // alu ops, lea and loads write a register and set the codes
        if (!e.wb && !e.wr && !e.redir && ir[15:12] != 4'b1000 && ir[15:12] != 4'b0000)
        begin
            e.wb = 1'b1;
            e.cc = 1'b1;
        end
        return e;
    endfunction

    task automatic commit(input outcome_t e);
        if (e.wb)
            m_reg[e.dest] = e.data;
        if (e.cc)
            m_nzp = nzp_of(e.data);
        if (e.wr)
            ref_mem[e.addr[6:1]] = e.wdata;
    endtask

    task automatic check_word(input string what, input lc3b_types::lc3b_word exp,
                              input lc3b_types::lc3b_word act);
        if (act !== exp)
        begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_reg(input string what, input lc3b_types::lc3b_reg exp,
                             input lc3b_types::lc3b_reg act);
        if (act !== exp)
        begin
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_nzp(input string what, input lc3b_types::lc3b_nzp exp,
                             input lc3b_types::lc3b_nzp act);
        if (act !== exp)
        begin
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_w(input outcome_t e);
        check_bit("wb_valid", e.wb, wb_valid);
        if (e.wb)
        begin
            check_reg("wb_dest", e.dest, wb_dest);
            check_word("wb_data", e.data, wb_data);
        end
        check_bit("redirect", e.redir, redirect);
        if (e.redir)
            check_word("redirect_target", e.target, redirect_target);
        check_bit("dmem_read", e.rd, dmem_read);
        check_bit("dmem_write", e.wr, dmem_write);
        if (e.rd || e.wr)
            check_word("dmem_addr", e.addr, dmem_addr);
        if (e.wr)
            check_word("dmem_wdata", e.wdata, dmem_wdata);
    endtask

    task automatic queue_instr(input lc3b_types::lc3b_word ir, input lc3b_types::lc3b_word pc);
        ir_q.push_back(ir);
        pc_q.push_back(pc);
    endtask

    // issue the queued instructions back to back, each retires three cycles later
    task automatic run_block();
        outcome_t exp_q [$];
        int       n;
        n = ir_q.size();
        foreach (ir_q[i])
        begin
            exp_q.push_back(predict(ir_q[i], pc_q[i]));
            commit(exp_q[i]);
        end
        for (int t = 0; t < n + 3; t++)
        begin
            @(negedge clk);
            if (t < n)
            begin
                instr       = ir_q.pop_front();
                instr_pc    = pc_q.pop_front();
                instr_valid = 1'b1;
            end
            else
            begin
                instr_valid = 1'b0;
            end
            if (t >= 3)
            begin
                compare_w(exp_q.pop_front());
            end
            else
            begin
                check_bit("early wb_valid", 1'b0, wb_valid);
                check_bit("early redirect", 1'b0, redirect);
            end
        end
        @(negedge clk);
        check_nzp("cc_nzp", m_nzp, cc_nzp);
    endtask

    task automatic run_one(input lc3b_types::lc3b_word ir, input lc3b_types::lc3b_word pc);
        queue_instr(ir, pc);
        run_block();
    endtask

    // lea with a zero offset copies the pc into the register
    task automatic load_value(input lc3b_types::lc3b_reg r, input lc3b_types::lc3b_word v);
        run_one(enc(lc3b_types::op_lea, r, 3'b000, 6'b000000), v);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_start_errors)
        begin
            $display("%s: ok", test_name);
            pass_count++;
        end
        else
        begin
            $display("%s: failed with %0d errors", test_name, error_count - test_start_errors);
            fail_count++;
        end
    endtask

    task automatic reset_and_bubbles();
        start_test("reset_and_bubbles");
        repeat (3)
        begin
            @(negedge clk);
            check_bit("idle wb_valid", 1'b0, wb_valid);
            check_bit("idle dmem_read", 1'b0, dmem_read);
            check_bit("idle dmem_write", 1'b0, dmem_write);
            check_bit("idle redirect", 1'b0, redirect);
        end
        check_nzp("reset cc_nzp", 3'b010, cc_nzp);
        // rti is not decoded and must retire as a bubble
        run_one(enc(lc3b_types::op_rti, 3'b000, 3'b000, 6'b000000), 16'h0100);
        finish_test();
    endtask

    task automatic arithmetic_ops();
        lc3b_types::lc3b_word a;
        lc3b_types::lc3b_word b;
        lc3b_types::lc3b_word imm;
        lc3b_types::lc3b_word amt;
        start_test("arithmetic_ops");
        random_bits(16, a);
        random_bits(16, b);
        random_bits(5, imm);
        random_bits(4, amt);
        // negative operand so the arithmetic shift fills with ones
        a[15] = 1'b1;
        load_value(3'd1, a);
        load_value(3'd2, b);
        run_one(enc(lc3b_types::op_add, 3'd3, 3'd1, 6'b000010), 16'h3000);
        run_one(enc(lc3b_types::op_add, 3'd4, 3'd1, {1'b1, imm[4:0]}), 16'h3002);
        run_one(enc(lc3b_types::op_and, 3'd5, 3'd1, 6'b000010), 16'h3004);
        run_one(enc(lc3b_types::op_and, 3'd6, 3'd2, {1'b1, imm[4:0]}), 16'h3006);
        run_one(enc(lc3b_types::op_not, 3'd7, 3'd1, 6'b111111), 16'h3008);
        run_one(enc(lc3b_types::op_shf, 3'd3, 3'd1, {2'b00, amt[3:0]}), 16'h300A);
        run_one(enc(lc3b_types::op_shf, 3'd4, 3'd1, {2'b01, amt[3:0]}), 16'h300C);
        run_one(enc(lc3b_types::op_shf, 3'd5, 3'd1, {2'b11, amt[3:0]}), 16'h300E);
        finish_test();
    endtask

    task automatic pipelined_throughput();
        lc3b_types::lc3b_word imm;
        start_test("pipelined_throughput");
        random_bits(5, imm);
        queue_instr(enc(lc3b_types::op_add, 3'd3, 3'd1, 6'b000010), 16'h4000);
        queue_instr(enc(lc3b_types::op_and, 3'd4, 3'd1, 6'b000010), 16'h4002);
        queue_instr(enc(lc3b_types::op_not, 3'd5, 3'd2, 6'b111111), 16'h4004);
        queue_instr(enc(lc3b_types::op_add, 3'd6, 3'd2, {1'b1, imm[4:0]}), 16'h4006);
        run_block();
        finish_test();
    endtask

    task automatic memory_access();
        lc3b_types::lc3b_word data;
        start_test("memory_access");
        random_bits(16, data);
        load_value(3'd1, 16'h0010);
        load_value(3'd2, data);
        run_one(enc(lc3b_types::op_str, 3'd2, 3'd1, 6'd3), 16'h5000);
        run_one(enc(lc3b_types::op_ldr, 3'd3, 3'd1, 6'd3), 16'h5002);
        run_one(enc(lc3b_types::op_ldb, 3'd4, 3'd1, 6'd6), 16'h5004);
        run_one(enc(lc3b_types::op_ldb, 3'd5, 3'd1, 6'd7), 16'h5006);
        finish_test();
    endtask

    task automatic control_transfer();
        lc3b_types::lc3b_word off;
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word tgt;
        start_test("control_transfer");
        for (int k = 0; k < 3; k++)
        begin
            // negative, zero, then positive condition codes
            load_value(3'd6, k == 0 ? 16'hF00D : (k == 1 ? 16'h0000 : 16'h0123));
            for (int m = 0; m < 8; m++)
            begin
                random_bits(9, off);
                random_bits(16, pc);
                pc[0] = 1'b0;
                run_one(enc(lc3b_types::op_br, m[2:0], off[8:6], off[5:0]), pc);
            end
        end
        random_bits(16, tgt);
        tgt[0] = 1'b0;
        load_value(3'd3, tgt);
        run_one(enc(lc3b_types::op_jmp, 3'b000, 3'd3, 6'b000000), 16'h6000);
        random_bits(11, off);
        run_one(enc(lc3b_types::op_jsr, {1'b1, off[10:9]}, off[8:6], off[5:0]), 16'h6100);
        run_one(enc(lc3b_types::op_jsr, 3'b000, 3'd3, 6'b000000), 16'h6200);
        // vector 0x25 reads the word at byte address 0x4a
        run_one(enc(lc3b_types::op_trap, 3'b000, 3'b000, 6'h25), 16'h6300);
        run_one(enc(lc3b_types::op_jmp, 3'b000, 3'd7, 6'b000000), 16'h6400);
        finish_test();
    endtask

    initial
    begin
        rst         = 1'b1;
        instr       = '0;
        instr_pc    = '0;
        instr_valid = 1'b0;
        lfsr_state  = 16'd61083;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        m_nzp       = 3'b010;
        for (int i = 0; i < 8; i++)
            m_reg[i[2:0]] = '0;
        for (int i = 0; i < 64; i++)
            ref_mem[i[5:0]] = fill_word(i[5:0]);
        repeat (4) @(negedge clk);
        rst = 1'b0;

        reset_and_bubbles();
        arithmetic_ops();
        pipelined_throughput();
        memory_access();
        control_transfer();

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : tb_lc3b_core

`default_nettype wire

// File: lc3b_core.f
lc3b_types.sv
control_rom.sv
regfile.sv
alu.sv
lc3b_core.sv
tb_lc3b_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc3b_core
FILELIST  ?= lc3b_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
